//--- hdl/decode_pkg.sv
package decode_pkg;

    // data and address widths fixed by the instruction set
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // one-hot op vectors handed to the execute stage
    typedef logic [11:0] alu_op_t;
    typedef logic [7:0]  mem_op_t;

    // alu_op_t bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    // load upper immediate, passes src2 through
    localparam int ALU_LUI  = 11;

    // mem_op_t bit positions, loads first
    localparam int MEM_LD_B  = 0;
    localparam int MEM_LD_BU = 1;
    localparam int MEM_LD_H  = 2;
    localparam int MEM_LD_HU = 3;
    localparam int MEM_LD_W  = 4;
    localparam int MEM_ST_B  = 5;
    localparam int MEM_ST_H  = 6;
    localparam int MEM_ST_W  = 7;

    // bl writes its return address here
    localparam reg_addr_t LINK_REG = 5'd1;

    // kind of control transfer, resolved in decode
    typedef enum logic [3:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_JIRL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_kind_t;

endpackage

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  inst_t     inst,
    output alu_op_t   alu_op,
    output mem_op_t   mem_op,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd_dest,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output logic      gr_we,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output word_t     imm,
    output br_kind_t  br_kind,
    output word_t     br_offs,
    output logic      illegal
);

    logic [5:0] op6;
    logic [3:0] op4;
    logic [1:0] op2;
    logic [4:0] op5;
    reg_addr_t  rd;
    reg_addr_t  rk;
    logic       grp_3r;
    logic       grp_shift;
    logic       grp_2ri12;
    logic       grp_mem;
    logic       is_add, is_sub, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
    logic       is_sll, is_srl, is_sra, is_slli, is_srli, is_srai;
    logic       is_addi, is_slti, is_sltui, is_andi, is_ori, is_xori;
    logic       is_lu12i, is_pcaddu12i;
    logic       is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    logic       is_load, is_store, is_cbranch, any_inst;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rk  = inst[14:10];

    // major opcode groups
    assign grp_3r    = (op6 == 6'h00) && (op4 == 4'h0) && (op2 == 2'h1);
    assign grp_shift = (op6 == 6'h00) && (op4 == 4'h1) && (op2 == 2'h0);
    assign grp_2ri12 = (op6 == 6'h00);
    assign grp_mem   = (op6 == 6'h0a);

    assign is_add  = grp_3r && (op5 == 5'h00);
    assign is_sub  = grp_3r && (op5 == 5'h02);
    assign is_slt  = grp_3r && (op5 == 5'h04);
    assign is_sltu = grp_3r && (op5 == 5'h05);
    assign is_nor  = grp_3r && (op5 == 5'h08);
    assign is_and  = grp_3r && (op5 == 5'h09);
    assign is_or   = grp_3r && (op5 == 5'h0a);
    assign is_xor  = grp_3r && (op5 == 5'h0b);
    assign is_sll  = grp_3r && (op5 == 5'h0e);
    assign is_srl  = grp_3r && (op5 == 5'h0f);
    assign is_sra  = grp_3r && (op5 == 5'h10);
    assign is_slli = grp_shift && (op5 == 5'h01);
    assign is_srli = grp_shift && (op5 == 5'h09);
    assign is_srai = grp_shift && (op5 == 5'h11);

    assign is_slti  = grp_2ri12 && (op4 == 4'h8);
    assign is_sltui = grp_2ri12 && (op4 == 4'h9);
    assign is_addi  = grp_2ri12 && (op4 == 4'ha);
    assign is_andi  = grp_2ri12 && (op4 == 4'hd);
    assign is_ori   = grp_2ri12 && (op4 == 4'he);
    assign is_xori  = grp_2ri12 && (op4 == 4'hf);

    assign is_lu12i     = (op6 == 6'h05) && !inst[25];
    assign is_pcaddu12i = (op6 == 6'h07) && !inst[25];

    assign is_jirl = (op6 == 6'h13);
    assign is_b    = (op6 == 6'h14);
    assign is_bl   = (op6 == 6'h15);
    assign is_beq  = (op6 == 6'h16);
    assign is_bne  = (op6 == 6'h17);
    assign is_blt  = (op6 == 6'h18);
    assign is_bge  = (op6 == 6'h19);
    assign is_bltu = (op6 == 6'h1a);
    assign is_bgeu = (op6 == 6'h1b);

    assign mem_op[MEM_LD_B]  = grp_mem && (op4 == 4'h0);
    assign mem_op[MEM_LD_H]  = grp_mem && (op4 == 4'h1);
    assign mem_op[MEM_LD_W]  = grp_mem && (op4 == 4'h2);
    assign mem_op[MEM_ST_B]  = grp_mem && (op4 == 4'h4);
    assign mem_op[MEM_ST_H]  = grp_mem && (op4 == 4'h5);
    assign mem_op[MEM_ST_W]  = grp_mem && (op4 == 4'h6);
    assign mem_op[MEM_LD_BU] = grp_mem && (op4 == 4'h8);
    assign mem_op[MEM_LD_HU] = grp_mem && (op4 == 4'h9);

    assign is_load    = |mem_op[MEM_LD_W:MEM_LD_B];
    assign is_store   = |mem_op[MEM_ST_W:MEM_ST_B];
    assign is_cbranch = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

    // address adds and link computation share the adder
    assign alu_op[ALU_ADD]  = is_add | is_addi | is_load | is_store | is_jirl | is_bl
                            | is_pcaddu12i;
    assign alu_op[ALU_SUB]  = is_sub;
    assign alu_op[ALU_SLT]  = is_slt | is_slti;
    assign alu_op[ALU_SLTU] = is_sltu | is_sltui;
    assign alu_op[ALU_AND]  = is_and | is_andi;
    assign alu_op[ALU_NOR]  = is_nor;
    assign alu_op[ALU_OR]   = is_or | is_ori;
    assign alu_op[ALU_XOR]  = is_xor | is_xori;
    assign alu_op[ALU_SLL]  = is_sll | is_slli;
    assign alu_op[ALU_SRL]  = is_srl | is_srli;
    assign alu_op[ALU_SRA]  = is_sra | is_srai;
    assign alu_op[ALU_LUI]  = is_lu12i;

    assign any_inst = (|alu_op) | is_store | is_b | is_cbranch;
    assign illegal  = !any_inst;

    // branches and stores read rd as their second source
    assign rs1      = inst[9:5];
    assign rs2      = (is_cbranch || is_store) ? rd : rk;
    assign rd_dest  = is_bl ? LINK_REG : rd;
    assign uses_rs1 = any_inst && !(is_lu12i || is_pcaddu12i || is_b || is_bl);
    assign uses_rs2 = grp_3r && any_inst || is_cbranch || is_store;
    assign gr_we    = any_inst && !(is_store || is_cbranch || is_b);

    assign src1_is_pc  = is_jirl | is_bl | is_pcaddu12i;
    assign src2_is_imm = is_slli | is_srli | is_srai | is_addi | is_slti | is_sltui
                       | is_andi | is_ori | is_xori | is_lu12i | is_pcaddu12i
                       | is_load | is_store | is_jirl | is_bl;

    // shift amounts come out of the low bits of the si12 form
    assign imm = (is_jirl || is_bl)           ? 32'd4 :
                 (is_andi || is_ori || is_xori) ? {20'h0, inst[21:10]} :
                 (is_lu12i || is_pcaddu12i)   ? {inst[24:5], 12'h0} :
                                                {{20{inst[21]}}, inst[21:10]};

    assign br_offs = (is_b || is_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                                     : {{14{inst[25]}}, inst[25:10], 2'b00};

    always_comb begin
        if (is_b)         br_kind = BR_B;
        else if (is_bl)   br_kind = BR_BL;
        else if (is_jirl) br_kind = BR_JIRL;
        else if (is_beq)  br_kind = BR_BEQ;
        else if (is_bne)  br_kind = BR_BNE;
        else if (is_blt)  br_kind = BR_BLT;
        else if (is_bge)  br_kind = BR_BGE;
        else if (is_bltu) br_kind = BR_BLTU;
        else if (is_bgeu) br_kind = BR_BGEU;
        else              br_kind = BR_NONE;
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import decode_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t waddr,
    input  logic      we,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    // one write port, fed from writeback
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import decode_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      uses_rs1,
    input  logic      uses_rs2,
    input  word_t     rf_data1,
    input  word_t     rf_data2,
    input  reg_addr_t ex_dest,
    input  reg_addr_t mem_dest,
    input  reg_addr_t wb_addr,
    input  word_t     ex_value,
    input  word_t     mem_value,
    input  word_t     wb_data,
    input  logic      wb_we,
    input  logic      ex_is_load,
    output word_t     rs1_value,
    output word_t     rs2_value,
    output logic      load_use_stall
);

    logic hit1_ex;
    logic hit2_ex;

    // youngest producer wins; a zero source never matches a
    // stage because it is caught first
    function automatic word_t pick(input reg_addr_t rs, input word_t rf_val);
        word_t val;
        if (rs == '0) begin
            val = '0;
        end else if (rs == ex_dest) begin
            val = ex_value;
        end else if (rs == mem_dest) begin
            val = mem_value;
        end else if (wb_we && (rs == wb_addr)) begin
            val = wb_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        rs1_value = pick(rs1, rf_data1);
        rs2_value = pick(rs2, rf_data2);
    end

    assign hit1_ex = uses_rs1 && (rs1 == ex_dest);
    assign hit2_ex = uses_rs2 && (rs2 == ex_dest);

    // load data is not ready until the memory stage
    assign load_use_stall = ex_is_load && (ex_dest != '0) && (hit1_ex || hit2_ex);

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
    input  br_kind_t br_kind,
    input  word_t    pc,
    input  word_t    rs1_value,
    input  word_t    rs2_value,
    input  word_t    br_offs,
    output logic     cond_true,
    output word_t    target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_value == rs2_value);
    assign lt_s = ($signed(rs1_value) < $signed(rs2_value));
    assign lt_u = (rs1_value < rs2_value);

    always_comb begin
        case (br_kind)
            BR_B, BR_BL, BR_JIRL: cond_true = 1'b1;
            BR_BEQ:               cond_true = eq;
            BR_BNE:               cond_true = !eq;
            BR_BLT:               cond_true = lt_s;
            BR_BGE:               cond_true = !lt_s;
            BR_BLTU:              cond_true = lt_u;
            BR_BGEU:              cond_true = !lt_u;
            default:              cond_true = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target = (br_kind == BR_JIRL) ? (rs1_value + br_offs) : (pc + br_offs);

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  word_t     in_pc,
    input  inst_t     in_inst,
    input  logic      next_allowin,
    input  logic      flush,
    input  reg_addr_t ex_dest,
    input  word_t     ex_value,
    input  logic      ex_is_load,
    input  reg_addr_t mem_dest,
    input  word_t     mem_value,
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      allowin,
    output logic      out_valid,
    output alu_op_t   alu_op,
    output mem_op_t   mem_op,
    output logic      reg_write,
    output reg_addr_t dest,
    output word_t     src1,
    output word_t     src2,
    output word_t     store_data,
    output word_t     pc_out,
    output logic      illegal_inst,
    output logic      br_taken,
    output word_t     br_target
);

    logic      ds_valid;
    logic      ready_go;
    word_t     ds_pc;
    inst_t     ds_inst;
    reg_addr_t rs1, rs2;
    logic      uses_rs1, uses_rs2;
    logic      gr_we, src1_is_pc, src2_is_imm, illegal;
    word_t     imm, br_offs;
    br_kind_t  br_kind;
    word_t     rf_data1, rf_data2;
    word_t     rs1_value, rs2_value;
    logic      load_use_stall;
    logic      cond_true;

    // flush overrides a pending stall so the stage can drain
    assign ready_go  = !load_use_stall || flush;
    assign allowin   = !ds_valid || (ready_go && next_allowin);
    assign out_valid = ds_valid && ready_go && !flush;
    assign br_taken  = out_valid && cond_true;

    // a taken branch leaving decode drops the slot fetched behind it
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush || (br_taken && next_allowin)) begin
            ds_valid <= 1'b0;
        end else if (allowin) begin
            ds_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            ds_pc   <= in_pc;
            ds_inst <= in_inst;
        end
    end

    inst_decoder u_dec (
        .inst        (ds_inst),
        .alu_op      (alu_op),
        .mem_op      (mem_op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd_dest     (dest),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .gr_we       (gr_we),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .imm         (imm),
        .br_kind     (br_kind),
        .br_offs     (br_offs),
        .illegal     (illegal)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .waddr  (wb_addr),
        .we     (wb_we),
        .wdata  (wb_data),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2)
    );

    operand_bypass u_byp (
        .rs1            (rs1),
        .rs2            (rs2),
        .uses_rs1       (uses_rs1),
        .uses_rs2       (uses_rs2),
        .rf_data1       (rf_data1),
        .rf_data2       (rf_data2),
        .ex_dest        (ex_dest),
        .mem_dest       (mem_dest),
        .wb_addr        (wb_addr),
        .ex_value       (ex_value),
        .mem_value      (mem_value),
        .wb_data        (wb_data),
        .wb_we          (wb_we),
        .ex_is_load     (ex_is_load),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_br (
        .br_kind   (br_kind),
        .pc        (ds_pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .br_offs   (br_offs),
        .cond_true (cond_true),
        .target    (br_target)
    );

    assign src1         = src1_is_pc ? ds_pc : rs1_value;
    assign src2         = src2_is_imm ? imm : rs2_value;
    assign store_data   = rs2_value;
    assign pc_out       = ds_pc;
    assign reg_write    = ds_valid && gr_we;
    assign illegal_inst = ds_valid && illegal;

endmodule

//--- test/inst_table.svh
// opcode templates of the kept instructions, one kind per index
//  0..10 register ALU ops, 11..13 immediate shifts, 14..19 2ri12 ALU ops
//  20..27 ld.b ld.bu ld.h ld.hu ld.w st.b st.h st.w
//  28 lu12i.w, 29 pcaddu12i, 30 jirl, 31 b, 32 bl, 33..38 beq bne blt bge bltu bgeu
localparam int NUM_KINDS = 39;

function automatic logic [31:0] inst_template(input int k);
    logic [31:0] t;
    case (k)
        0:  t = 32'h0010_0000;
        1:  t = 32'h0011_0000;
        2:  t = 32'h0012_0000;
        3:  t = 32'h0012_8000;
        4:  t = 32'h0014_0000;
        5:  t = 32'h0014_8000;
        6:  t = 32'h0015_0000;
        7:  t = 32'h0015_8000;
        8:  t = 32'h0017_0000;
        9:  t = 32'h0017_8000;
        10: t = 32'h0018_0000;
        11: t = 32'h0040_8000;
        12: t = 32'h0044_8000;
        13: t = 32'h0048_8000;
        14: t = 32'h0200_0000;
        15: t = 32'h0240_0000;
        16: t = 32'h0280_0000;
        17: t = 32'h0340_0000;
        18: t = 32'h0380_0000;
        19: t = 32'h03c0_0000;
        20: t = 32'h2800_0000;
        21: t = 32'h2a00_0000;
        22: t = 32'h2840_0000;
        23: t = 32'h2a40_0000;
        24: t = 32'h2880_0000;
        25: t = 32'h2900_0000;
        26: t = 32'h2940_0000;
        27: t = 32'h2980_0000;
        28: t = 32'h1400_0000;
        29: t = 32'h1c00_0000;
        default: t = (32'h13 + k - 30) << 26;
    endcase
    return t;
endfunction

// bits of the word that carry registers and immediates
function automatic logic [31:0] free_mask(input int k);
    logic [31:0] m;
    if (k <= 13) begin
        m = 32'h0000_7fff;
    end else if (k <= 27) begin
        m = 32'h003f_ffff;
    end else if (k <= 29) begin
        m = 32'h01ff_ffff;
    end else begin
        m = 32'h03ff_ffff;
    end
    return m;
endfunction

//--- test/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  word_t     in_pc,
    input  inst_t     in_inst,
    input  logic      next_allowin,
    input  logic      flush,
    input  reg_addr_t ex_dest,
    input  word_t     ex_value,
    input  logic      ex_is_load,
    input  reg_addr_t mem_dest,
    input  word_t     mem_value,
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      allowin,
    input  logic      out_valid,
    input  alu_op_t   alu_op,
    input  mem_op_t   mem_op,
    input  logic      reg_write,
    input  reg_addr_t dest,
    input  word_t     src1,
    input  word_t     src2,
    input  word_t     store_data,
    input  word_t     pc_out,
    input  logic      illegal_inst,
    input  logic      br_taken,
    input  word_t     br_target,
    output int        error_count,
    output int        check_count
);

    `include "inst_table.svh"

    // model state: stage valid, latch and register file mirror
    logic      m_valid;
    word_t     m_pc;
    inst_t     m_inst;
    word_t     mrf [32];

    int        k;
    reg_addr_t rs1, rs2;
    logic      u1, u2, we_k, pc1, rd2, has_imm, stall, rdy, cond;
    word_t     v1, v2, imm_e, offs16, offs26;
    logic      e_allowin, e_outv, e_taken;
    alu_op_t   e_alu;
    mem_op_t   e_mem;
    reg_addr_t e_dest;
    word_t     e_src1, e_src2, e_target;

    function automatic int kind_of(input inst_t w);
        for (int i = 0; i < NUM_KINDS; i++) begin
            if ((w & ~free_mask(i)) == inst_template(i)) return i;
        end
        return -1;
    endfunction

    function automatic int alu_index(input int kk);
        case (kk)
            0, 16, 20, 21, 22, 23, 24, 25, 26, 27, 29, 30, 32: return ALU_ADD;
            1:        return ALU_SUB;
            2, 14:    return ALU_SLT;
            3, 15:    return ALU_SLTU;
            4:        return ALU_NOR;
            5, 17:    return ALU_AND;
            6, 18:    return ALU_OR;
            7, 19:    return ALU_XOR;
            8, 11:    return ALU_SLL;
            9, 12:    return ALU_SRL;
            10, 13:   return ALU_SRA;
            28:       return ALU_LUI;
            default:  return -1;
        endcase
    endfunction

    // ex, then mem, then wb, then the mirror
    function automatic word_t fwd(input reg_addr_t r);
        if (r == 0) return '0;
        if (r == ex_dest) return ex_value;
        if (r == mem_dest) return mem_value;
        if (wb_we && r == wb_addr) return wb_data;
        return mrf[r];
    endfunction

    always_comb begin
        k       = kind_of(m_inst);
        rd2     = (k >= 25 && k <= 27) || k >= 33;
        rs1     = m_inst[9:5];
        rs2     = rd2 ? m_inst[4:0] : m_inst[14:10];
        u1      = k >= 0 && !(k == 28 || k == 29 || k == 31 || k == 32);
        u2      = (k >= 0 && k <= 10) || rd2;
        we_k    = k >= 0 && !((k >= 25 && k <= 27) || k == 31 || k >= 33);
        pc1     = k == 29 || k == 30 || k == 32;
        has_imm = (k >= 11 && k <= 30) || k == 32;
        v1      = fwd(rs1);
        v2      = fwd(rs2);
        if (k == 30 || k == 32) imm_e = 32'd4;
        else if (k >= 17 && k <= 19) imm_e = {20'h0, m_inst[21:10]};
        else if (k == 28 || k == 29) imm_e = {m_inst[24:5], 12'h0};
        else imm_e = {{20{m_inst[21]}}, m_inst[21:10]};
        offs16 = {{14{m_inst[25]}}, m_inst[25:10], 2'b00};
        offs26 = {{4{m_inst[9]}}, m_inst[9:0], m_inst[25:10], 2'b00};
        case (k)
            30, 31, 32: cond = 1'b1;
            33:         cond = v1 == v2;
            34:         cond = v1 != v2;
            35:         cond = $signed(v1) < $signed(v2);
            36:         cond = $signed(v1) >= $signed(v2);
            37:         cond = v1 < v2;
            38:         cond = v1 >= v2;
            default:    cond = 1'b0;
        endcase
        e_target = (k == 30) ? v1 + offs16 : (k == 31 || k == 32) ? m_pc + offs26
                                                                 : m_pc + offs16;
        e_alu = '0;
        if (alu_index(k) >= 0) e_alu[alu_index(k)] = 1'b1;
        e_mem = '0;
        if (k >= 20 && k <= 27) e_mem[k - 20] = 1'b1;
        e_dest    = (k == 32) ? LINK_REG : m_inst[4:0];
        e_src1    = pc1 ? m_pc : v1;
        e_src2    = has_imm ? imm_e : v2;
        stall     = ex_is_load && ex_dest != 0 && ((u1 && rs1 == ex_dest) || (u2 && rs2 == ex_dest));
        rdy       = !stall || flush;
        e_allowin = !m_valid || (rdy && next_allowin);
        e_outv    = m_valid && rdy && !flush;
        e_taken   = e_outv && cond;
    end

    initial begin
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < 32; i++) mrf[i] = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (flush || (e_taken && next_allowin)) begin
            m_valid <= 1'b0;
        end else if (e_allowin) begin
            m_valid <= in_valid;
        end
        if (in_valid && e_allowin) begin
            m_pc   <= in_pc;
            m_inst <= in_inst;
        end
        if (wb_we && wb_addr != 0) mrf[wb_addr] <= wb_data;
    end

    task automatic compare(input string name, input word_t exp, input word_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        if (!reset) begin
            compare("allowin", e_allowin, allowin);
            compare("out_valid", e_outv, out_valid);
            compare("br_taken", e_taken, br_taken);
            if (e_outv) begin
                compare("alu_op", e_alu, alu_op);
                compare("mem_op", e_mem, mem_op);
                compare("reg_write", we_k, reg_write);
                compare("illegal_inst", k < 0, illegal_inst);
                compare("src1", e_src1, src1);
                compare("src2", e_src2, src2);
                compare("store_data", v2, store_data);
                compare("pc_out", m_pc, pc_out);
                if (we_k) compare("dest", e_dest, dest);
                if (e_taken) compare("br_target", e_target, br_target);
            end
        end
    end

endmodule

//--- test/decode_stage_assert.sv
`timescale 1ns/1ps

module decode_stage_assert import decode_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      flush,
    input logic      next_allowin,
    input logic      out_valid,
    input logic      br_taken,
    input word_t     pc_out,
    input alu_op_t   alu_op,
    input mem_op_t   mem_op,
    input reg_addr_t dest
);

    // held by back-pressure, the latch must not move
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !next_allowin) |=>
            ($stable(pc_out) && $stable(alu_op) && $stable(mem_op) && $stable(dest)))
        else $error("outputs changed while held by back-pressure");

    // the slot fetched behind a taken branch is dropped
    taken_cancel: assert property (@(posedge clk) disable iff (reset)
        (br_taken && next_allowin) |=> !out_valid)
        else $error("out_valid high in the slot after a taken branch");

    flush_empty: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid)
        else $error("out_valid high after flush");

endmodule

bind decode_stage decode_stage_assert u_assert (.*);

//--- test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int INIT_CYCLES  = 32;
    localparam int TEST_CYCLES  = 4000;

    `include "inst_table.svh"

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid, next_allowin, flush, ex_is_load, wb_we;
    word_t     in_pc, ex_value, mem_value, wb_data;
    inst_t     in_inst;
    reg_addr_t ex_dest, mem_dest, wb_addr;
    logic      allowin, out_valid, reg_write, illegal_inst, br_taken;
    alu_op_t   alu_op;
    mem_op_t   mem_op;
    reg_addr_t dest;
    word_t     src1, src2, store_data, pc_out, br_target;
    int        error_count, check_count;
    logic [31:0] rng_state = 32'd89;

    always #(PERIOD / 2) clk = !clk;

    decode_stage dut0 (.*);

    decode_checker chk0 (.*);

    function logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // mostly encoded instructions on registers 0..7, some raw words
    function inst_t random_inst();
        logic [31:0] r;
        logic [31:0] w;
        int kk;
        r = lcg_next();
        w = lcg_next();
        if (r[31:29] == 3'd0) return w;
        kk = int'(r[23:8]) % NUM_KINDS;
        return inst_template(kk) | (w & free_mask(kk) & ~32'h0000_6318);
    endfunction

    task drive_random();
        logic [31:0] r;
        r = lcg_next();
        in_valid     <= r[17:16] != 2'd0;
        next_allowin <= r[19:18] != 2'd0;
        flush        <= r[24:20] == 5'd0;
        ex_is_load   <= r[26:25] == 2'd0;
        wb_we        <= r[27];
        ex_dest      <= {2'b00, r[30:28]};
        r = lcg_next();
        mem_dest     <= {2'b00, r[18:16]};
        wb_addr      <= {2'b00, r[22:20]};
        in_pc        <= lcg_next() & 32'hffff_fffc;
        in_inst      <= random_inst();
        ex_value     <= lcg_next();
        mem_value    <= lcg_next();
        wb_data      <= lcg_next();
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_inst      = '0;
        next_allowin = 1'b1;
        flush        = 1'b0;
        ex_dest      = '0;
        ex_value     = '0;
        ex_is_load   = 1'b0;
        mem_dest     = '0;
        mem_value    = '0;
        wb_we        = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // fill the register file through writeback
        for (int i = 1; i < 32; i++) begin
            @(posedge clk);
            wb_we   <= 1'b1;
            wb_addr <= i[4:0];
            wb_data <= lcg_next();
        end
        @(posedge clk);
        wb_we <= 1'b0;
        repeat (TEST_CYCLES) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((RESET_CYCLES + INIT_CYCLES + TEST_CYCLES + 100) * PERIOD);
        $display("timeout, simulation did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- decode_stage.f
+incdir+test
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/decode_stage.sv
test/decode_checker.sv
test/decode_stage_assert.sv
test/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f decode_stage.f \
    --top-module decode_stage_tb -o sim_decode > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_decode > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
